/* compile.f */
+incdir+testbench
hdl/fpu_float_pkg.sv
hdl/fpu_op_pkg.sv
hdl/fpu_unpack.sv
hdl/fpu_sign_cmp.sv
hdl/fpu_convert.sv
hdl/fpu_seq.sv
hdl/fpu_misc_top.sv
testbench/tb_fpu_misc.sv

/* hdl/fpu_convert.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_convert import fpu_float_pkg::*, fpu_op_pkg::*;
(
	input  fpu_req_t    req,
	input  fp_info_t    a,
	output fpu_result_t res
);

	localparam int   DROP_W   = MANT_W - SP_MANT_W;      // fraction bits lost going to single
	localparam int   FRAC_POS = MANT_W + 64;             // binary point inside the shifter
	localparam int   SH_W     = MANT_W + 129;
	localparam exp_t REBIAS   = exp_t'(BIAS - SP_BIAS);
	localparam exp_t EXP_LO   = exp_t'(BIAS - SP_BIAS + 1);  // smallest single normal
	localparam exp_t EXP_HI   = exp_t'(BIAS + SP_BIAS);      // largest single normal
	localparam exp_t BIAS_E   = exp_t'(BIAS);
	localparam exp_t INT_TOP  = exp_t'(BIAS + 63);

	logic [MANT_W:0] sig;
	logic [6:0]      shamt;
	logic [SH_W-1:0] shifted;
	fp64_t           int_mag;
	logic            frac_nz;
	logic            big;       // magnitude at or above 2^64
	logic            is32;
	logic            uns;
	fp64_t           pos_lim;
	fp64_t           neg_lim;   // magnitude of the most negative result
	fp64_t           int_val;
	logic            f2i_inv;

	logic                 sp_sign;
	logic [SP_EXP_W-1:0]  sp_exp;
	logic [SP_MANT_W-1:0] sp_frac;
	exp_t                 dp_exp;
	fp32_t                sp_word;
	fpu_result_t          f2f_res;

	//////////////////////////////
	// float to integer
	//////////////////////////////
	assign sig     = {1'b1, a.fraction};
	assign shamt   = 7'(a.exponent - BIAS_E) + 7'd64;
	assign shifted = SH_W'(sig) << shamt;
	assign is32    = (req.int_fmt == INT32);
	assign uns     = (req.op == OP_F2IU);

	always_comb
	begin
		if (a.exponent < BIAS_E)
		begin
			// below one, only the fraction survives
			int_mag = '0;
			frac_nz = ~a.is_zero;
			big     = 1'b0;
		end
		else if (a.exponent > INT_TOP)
		begin
			int_mag = '0;
			frac_nz = 1'b0;
			big     = 1'b1;
		end
		else
		begin
			int_mag = shifted[FRAC_POS +: 64];
			frac_nz = |shifted[FRAC_POS-1:0];
			big     = 1'b0;
		end

		case ({uns, is32})
			2'b00:   {pos_lim, neg_lim} = {64'h7FFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000};
			2'b01:   {pos_lim, neg_lim} = {64'h0000_0000_7FFF_FFFF, 64'h0000_0000_8000_0000};
			2'b10:   {pos_lim, neg_lim} = {64'hFFFF_FFFF_FFFF_FFFF, 64'h0};
			default: {pos_lim, neg_lim} = {64'h0000_0000_FFFF_FFFF, 64'h0};
		endcase

		f2i_inv = a.is_nan | big | (a.sign ? int_mag > neg_lim : int_mag > pos_lim);

		if (a.is_nan || (f2i_inv && !a.sign))
			int_val = pos_lim;
		else if (f2i_inv)
			int_val = -neg_lim;
		else
			int_val = a.sign ? -int_mag : int_mag;

		if (is32)
			int_val = {{32{int_val[31]}}, int_val[31:0]};  // 32-bit results sign-extend
	end

	//////////////////////////////
	// single <-> double
	//////////////////////////////
	assign {sp_sign, sp_exp, sp_frac} = req.opa[31:0];
	assign dp_exp = exp_t'(sp_exp) + REBIAS;

	always_comb
	begin
		f2f_res = '0;
		sp_word = '0;
		if (req.src_fmt == FMT_FP64 && req.dst_fmt == FMT_FP32)
		begin
			if (a.is_nan)
			begin
				sp_word = CANON_NAN32;
				f2f_res.flags.invalid = a.is_snan;
			end
			else if (a.is_inf || a.exponent > EXP_HI)
			begin
				sp_word = {a.sign, {SP_EXP_W{1'b1}}, {SP_MANT_W{1'b0}}};
				f2f_res.flags.overflow = ~a.is_inf;
				f2f_res.flags.inexact  = ~a.is_inf;
			end
			else if (a.is_zero || a.exponent < EXP_LO)
			begin
				sp_word = {a.sign, 31'b0};
				f2f_res.flags.underflow = ~a.is_zero;
				f2f_res.flags.inexact   = ~a.is_zero;
			end
			else
			begin
				sp_word = {a.sign, SP_EXP_W'(a.exponent - REBIAS), a.fraction[MANT_W-1 -: SP_MANT_W]};
				f2f_res.flags.inexact = |a.fraction[DROP_W-1:0];
			end
			f2f_res.value = {32'hFFFF_FFFF, sp_word};  // NaN-boxed
		end
		else if (req.src_fmt == FMT_FP32 && req.dst_fmt == FMT_FP64)
		begin
			if (&sp_exp && sp_frac == '0)
				f2f_res.value = {sp_sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
			else if (&sp_exp)
			begin
				f2f_res.value = CANON_NAN64;
				f2f_res.flags.invalid = ~sp_frac[SP_MANT_W-1];
			end
			else if (sp_exp == '0)
				f2f_res.value = {sp_sign, 63'b0};  // single subnormals flush to zero
			else
				f2f_res.value = {sp_sign, dp_exp, sp_frac, {DROP_W{1'b0}}};
		end
		else
			f2f_res = INVALID_RES;
	end

	always_comb
	begin
		res = '0;
		case (req.op)
			OP_F2I, OP_F2IU:
			begin
				res.value = int_val;
				res.flags.invalid = f2i_inv;
				res.flags.inexact = frac_nz & ~f2i_inv;
			end
			OP_F2F: res = f2f_res;
			default: res = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/fpu_float_pkg.sv */
`default_nettype none

package fpu_float_pkg;

	//////////////////////////////
	// double precision
	//////////////////////////////
	localparam int EXP_W  = 11;
	localparam int MANT_W = 52;
	localparam int BIAS   = 1023;

	//////////////////////////////
	// single precision
	//////////////////////////////
	localparam int SP_EXP_W  = 8;
	localparam int SP_MANT_W = 23;
	localparam int SP_BIAS   = 127;

	typedef logic [63:0]        fp64_t;  // double, boxed single or integer result
	typedef logic [31:0]        fp32_t;
	typedef logic [EXP_W-1:0]   exp_t;
	typedef logic [MANT_W-1:0]  mant_t;
	typedef logic [9:0]         class_mask_t;  // fclass result, one-hot

	// canonical quiet NaNs
	localparam fp64_t CANON_NAN64 = 64'h7FF8_0000_0000_0000;
	localparam fp32_t CANON_NAN32 = 32'h7FC0_0000;

	// one operand split into fields plus its class
	typedef struct packed {
		logic  sign;
		exp_t  exponent;
		mant_t fraction;
		logic  is_zero;
		logic  is_sub;
		logic  is_inf;
		logic  is_nan;
		logic  is_snan;  // also sets is_nan
	} fp_info_t;

endpackage

`default_nettype wire

/* hdl/fpu_misc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_misc_top import fpu_float_pkg::*, fpu_op_pkg::*;
#(
	parameter int RESULT_LATENCY = 3
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       enable,
	input  fpu_op_e    fpu_op,
	input  op_mod_t    op_mod,
	input  fmt_e       src_fmt,
	input  fmt_e       dst_fmt,
	input  int_fmt_e   int_fmt,
	input  fp64_t      opa,
	input  fp64_t      opb,
	output fp64_t      out,
	output fpu_flags_t flags,
	output logic       ready
);

	fpu_req_t    req;
	fp_info_t    info_a;
	fp_info_t    info_b;
	fpu_result_t cmp_res;   // sign injection, compare, min/max, classify
	fpu_result_t cnv_res;   // conversions

	fpu_seq #(
		.RESULT_LATENCY(RESULT_LATENCY)
	) seq_i (
		.clk(clk), .rst(rst), .enable(enable),
		.fpu_op(fpu_op), .op_mod(op_mod),
		.src_fmt(src_fmt), .dst_fmt(dst_fmt), .int_fmt(int_fmt),
		.opa(opa), .opb(opb),
		.req(req),
		.cmp_res(cmp_res), .cnv_res(cnv_res),
		.out(out), .flags(flags), .ready(ready)
	);

	fpu_unpack unpack_a_i (.op(req.opa), .info(info_a));
	fpu_unpack unpack_b_i (.op(req.opb), .info(info_b));

	fpu_sign_cmp sign_cmp_i (.req(req), .a(info_a), .b(info_b), .res(cmp_res));

	fpu_convert convert_i (.req(req), .a(info_a), .res(cnv_res));

endmodule

`default_nettype wire

/* hdl/fpu_op_pkg.sv */
`default_nettype none

package fpu_op_pkg;

	import fpu_float_pkg::*;

	// op codes as seen on the FPU op port
	typedef enum logic [4:0] {
		OP_SGNJ   = 5'd7,
		OP_CLASS  = 5'd8,
		OP_CMP    = 5'd9,
		OP_F2I    = 5'd10,
		OP_F2F    = 5'd15,
		OP_MINMAX = 5'd25,
		OP_F2IU   = 5'd26
	} fpu_op_e;

	typedef logic [2:0] op_mod_t;  // sub-function select

	typedef enum logic [2:0] {
		FMT_FP32 = 3'd0,
		FMT_FP64 = 3'd1
	} fmt_e;

	typedef enum logic [1:0] {
		INT32 = 2'd2,
		INT64 = 2'd3
	} int_fmt_e;

	typedef struct packed {
		logic invalid;
		logic divbyzero;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpu_flags_t;

	typedef struct packed {
		fp64_t      value;
		fpu_flags_t flags;
	} fpu_result_t;

	// answer for an op or sub-function that is not supported
	localparam fpu_result_t INVALID_RES = '{CANON_NAN64, '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0}};

	typedef struct packed {
		fpu_op_e  op;
		op_mod_t  mod;
		fmt_e     src_fmt;
		fmt_e     dst_fmt;
		int_fmt_e int_fmt;
		fp64_t    opa;
		fp64_t    opb;
	} fpu_req_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_DONE
	} seq_state_e;

endpackage

`default_nettype wire

/* hdl/fpu_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_seq import fpu_float_pkg::*, fpu_op_pkg::*;
#(
	parameter int RESULT_LATENCY = 3
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	input  fpu_op_e     fpu_op,
	input  op_mod_t     op_mod,
	input  fmt_e        src_fmt,
	input  fmt_e        dst_fmt,
	input  int_fmt_e    int_fmt,
	input  fp64_t       opa,
	input  fp64_t       opb,
	output fpu_req_t    req,
	input  fpu_result_t cmp_res,
	input  fpu_result_t cnv_res,
	output fp64_t       out,
	output fpu_flags_t  flags,
	output logic        ready
);

	localparam int CNT_W   = $clog2(RESULT_LATENCY + 1);
	localparam int LOAD_AT = (RESULT_LATENCY > 1) ? RESULT_LATENCY - 1 : 1;  // output register load

	seq_state_e       state;
	logic [CNT_W-1:0] cnt;       // cycles since the start edge
	logic             enable_d;
	logic             start;
	logic             started;   // a start was seen since reset
	fpu_result_t      merged;

	assign start = enable & ~enable_d;  // first edge with enable high

	// operands and op held for the whole operation
	always_ff @(posedge clk)
	begin
		if (start)
			req <= '{op: fpu_op, mod: op_mod, src_fmt: src_fmt, dst_fmt: dst_fmt,
				int_fmt: int_fmt, opa: opa, opb: opb};
	end

	// each unit returns zero for ops it does not own
	always_comb
	begin
		merged = cmp_res | cnv_res;
		case (req.op)
			OP_SGNJ, OP_CLASS, OP_CMP, OP_MINMAX, OP_F2I, OP_F2IU, OP_F2F: ;
			default: merged = INVALID_RES;
		endcase
	end

	//////////////////////////////
	// latency counter and output
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= ST_IDLE;
			cnt      <= '0;
			enable_d <= 1'b0;
			started  <= 1'b0;
			ready    <= 1'b0;
			out      <= '0;
			flags    <= '0;
		end
		else
		begin
			enable_d <= enable;
			if (start)
			begin
				state   <= ST_BUSY;   // restarts even while busy
				cnt     <= CNT_W'(1);
				started <= 1'b1;
				ready   <= 1'b0;
			end
			else if (state == ST_BUSY)
			begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(LOAD_AT))
				begin
					out   <= merged.value;
					flags <= merged.flags;
				end
				if (cnt == CNT_W'(RESULT_LATENCY))
				begin
					state <= ST_DONE;
					ready <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	assert property (@(posedge clk) disable iff (rst) ready |-> state == ST_DONE)
		else $error("fpu_seq: ready outside the done state");

	// ready never shows up before the first start after reset
	assert property (@(posedge clk) disable iff (rst) ready |-> started)
		else $error("fpu_seq: ready without a start");

endmodule

`default_nettype wire

/* hdl/fpu_sign_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_sign_cmp import fpu_float_pkg::*, fpu_op_pkg::*;
(
	input  fpu_req_t    req,
	input  fp_info_t    a,
	input  fp_info_t    b,
	output fpu_result_t res
);

	logic [EXP_W+MANT_W-1:0] mag_a;
	logic [EXP_W+MANT_W-1:0] mag_b;
	logic        any_nan;
	logic        any_snan;
	logic        both_zero;
	logic        eq;
	logic        lt;
	logic        lt_tot;  // lt with -0 ordered below +0
	class_mask_t cls;

	assign mag_a     = {a.exponent, a.fraction};
	assign mag_b     = {b.exponent, b.fraction};
	assign any_nan   = a.is_nan | b.is_nan;
	assign any_snan  = a.is_snan | b.is_snan;
	assign both_zero = a.is_zero & b.is_zero;
	assign eq        = both_zero | (a.sign == b.sign && mag_a == mag_b);

	//////////////////////////////
	// sign-magnitude ordering
	//////////////////////////////
	always_comb
	begin
		if (both_zero)
			lt = 1'b0;
		else if (a.sign != b.sign)
			lt = a.sign;             // negative below positive
		else if (a.sign)
			lt = mag_a > mag_b;      // both negative, bigger magnitude is smaller
		else
			lt = mag_a < mag_b;
	end

	assign lt_tot = lt | (both_zero & a.sign & ~b.sign);

	// fclass of operand a
	always_comb
	begin
		cls = '0;
		if (a.is_snan)
			cls[8] = 1'b1;
		else if (a.is_nan)
			cls[9] = 1'b1;
		else if (a.is_inf)
			cls[a.sign ? 0 : 7] = 1'b1;
		else if (a.is_zero)
			cls[a.sign ? 3 : 4] = 1'b1;
		else if (a.is_sub)
			cls[a.sign ? 2 : 5] = 1'b1;
		else
			cls[a.sign ? 1 : 6] = 1'b1;
	end

	//////////////////////////////
	// result select
	//////////////////////////////
	always_comb
	begin
		res = '0;
		case (req.op)
			OP_SGNJ:
				case (req.mod)
					3'd0: res.value = {b.sign, mag_a};
					3'd1: res.value = {a.sign ^ b.sign, mag_a};
					3'd2: res.value = {~b.sign, mag_a};
					3'd3: res.value = req.opa;  // raw move
					default: res = INVALID_RES;
				endcase
			OP_CMP:
				case (req.mod)
					3'd0:
					begin
						res.value = fp64_t'((lt | eq) & ~any_nan);  // fle
						res.flags.invalid = any_nan;
					end
					3'd1:
					begin
						res.value = fp64_t'(lt & ~any_nan);  // flt
						res.flags.invalid = any_nan;
					end
					3'd2:
					begin
						// feq is a quiet compare
						res.value = fp64_t'(eq & ~any_nan);
						res.flags.invalid = any_snan;
					end
					default: res = INVALID_RES;
				endcase
			OP_MINMAX:
				if (req.mod > 3'd1)
					res = INVALID_RES;
				else
				begin
					res.flags.invalid = any_snan;
					if (a.is_nan && b.is_nan)
						res.value = CANON_NAN64;
					else if (a.is_nan)
						res.value = req.opb;
					else if (b.is_nan)
						res.value = req.opa;
					else if (lt_tot ^ req.mod[0])  // mod 0 min, mod 1 max
						res.value = req.opa;
					else
						res.value = req.opb;
				end
			OP_CLASS: res.value = fp64_t'(cls);
			default: res = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/fpu_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_unpack import fpu_float_pkg::*;
(
	input  fp64_t    op,
	output fp_info_t info
);

	logic exp_max;   // exponent all ones
	logic exp_zero;
	logic frac_nz;

	// the packed layout of a double is sign, exponent, fraction
	assign {info.sign, info.exponent, info.fraction} = op;

	assign exp_max  = &info.exponent;
	assign exp_zero = ~|info.exponent;
	assign frac_nz  = |info.fraction;

	assign info.is_zero = exp_zero & ~frac_nz;
	assign info.is_sub  = exp_zero & frac_nz;
	assign info.is_inf  = exp_max & ~frac_nz;
	assign info.is_nan  = exp_max & frac_nz;
	assign info.is_snan = info.is_nan & ~info.fraction[MANT_W-1];  // quiet bit clear

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_fpu_misc \
	--Mdir obj_dir -o sim_fpu_misc
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_fpu_misc)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
else
	exit 1
fi

/* testbench/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// doubles that several entries share
localparam fp64_t P_ONE   = 64'h3FF0_0000_0000_0000;
localparam fp64_t M_ONE   = 64'hBFF0_0000_0000_0000;
localparam fp64_t P_1P5   = 64'h3FF8_0000_0000_0000;
localparam fp64_t M_1P5   = 64'hBFF8_0000_0000_0000;
localparam fp64_t P_TWO   = 64'h4000_0000_0000_0000;
localparam fp64_t M_TWO   = 64'hC000_0000_0000_0000;
localparam fp64_t P_2P5   = 64'h4004_0000_0000_0000;
localparam fp64_t M_2P5   = 64'hC004_0000_0000_0000;
localparam fp64_t P_THREE = 64'h4008_0000_0000_0000;
localparam fp64_t P_HALF  = 64'h3FE0_0000_0000_0000;
localparam fp64_t M_HALF  = 64'hBFE0_0000_0000_0000;
localparam fp64_t P_ZERO  = 64'h0000_0000_0000_0000;
localparam fp64_t M_ZERO  = 64'h8000_0000_0000_0000;
localparam fp64_t P_INF   = 64'h7FF0_0000_0000_0000;
localparam fp64_t M_INF   = 64'hFFF0_0000_0000_0000;
localparam fp64_t QNAN    = 64'h7FF8_0000_0000_0000;
localparam fp64_t SNAN    = 64'h7FF4_0000_0000_0000;  // quiet bit clear
localparam fp64_t QNAN_PP = 64'h7FF8_0000_0000_0002;  // quiet NaN carrying a payload
localparam fp64_t QNAN_PN = 64'hFFF8_0000_0000_0001;  // negative quiet NaN with a payload
localparam fp64_t P_SUB   = 64'h0000_0000_0000_0001;
localparam fp64_t M_SUB   = 64'h8000_0000_0000_0001;
localparam fp64_t P_2E31  = 64'h41E0_0000_0000_0000;
localparam fp64_t M_2E31  = 64'hC1E0_0000_0000_0000;
localparam fp64_t P_2E32  = 64'h41F0_0000_0000_0000;
localparam fp64_t M_2E32  = 64'hC1F0_0000_0000_0000;
localparam fp64_t P_2E63  = 64'h43E0_0000_0000_0000;
localparam fp64_t P_2E64  = 64'h43F0_0000_0000_0000;

// flag sets in the order invalid divbyzero overflow underflow inexact
localparam fpu_flags_t F_NONE = 5'b00000;
localparam fpu_flags_t F_NV   = 5'b10000;
localparam fpu_flags_t F_NX   = 5'b00001;
localparam fpu_flags_t F_OF   = 5'b00101;
localparam fpu_flags_t F_UF   = 5'b00011;

// each entry gives op, mod, opa, opb, expected out and expected flags
task automatic load_table;
	use_formats(FMT_FP64, FMT_FP64, INT64);
	add_case(OP_SGNJ, 3'd0, P_1P5, M_TWO, M_1P5, F_NONE);
	add_case(OP_SGNJ, 3'd1, P_1P5, M_TWO, M_1P5, F_NONE);
	add_case(OP_SGNJ, 3'd2, P_1P5, M_TWO, P_1P5, F_NONE);
	add_case(OP_SGNJ, 3'd1, M_1P5, M_TWO, P_1P5, F_NONE);   // two signs cancel
	add_case(OP_SGNJ, 3'd3, SNAN, P_ONE, SNAN, F_NONE);     // raw move
	add_case(OP_SGNJ, 3'd4, P_ONE, P_ONE, QNAN, F_NV);
	add_case(fpu_op_e'(5'd0), 3'd0, P_ONE, P_ONE, QNAN, F_NV);

	// one classify entry per class
	add_case(OP_CLASS, 3'd0, M_INF, P_ZERO, 64'h001, F_NONE);
	add_case(OP_CLASS, 3'd0, M_ONE, P_ZERO, 64'h002, F_NONE);
	add_case(OP_CLASS, 3'd0, M_SUB, P_ZERO, 64'h004, F_NONE);
	add_case(OP_CLASS, 3'd0, M_ZERO, P_ZERO, 64'h008, F_NONE);
	add_case(OP_CLASS, 3'd0, P_ZERO, P_ZERO, 64'h010, F_NONE);
	add_case(OP_CLASS, 3'd0, P_SUB, P_ZERO, 64'h020, F_NONE);
	add_case(OP_CLASS, 3'd0, P_ONE, P_ZERO, 64'h040, F_NONE);
	add_case(OP_CLASS, 3'd0, P_INF, P_ZERO, 64'h080, F_NONE);
	add_case(OP_CLASS, 3'd0, SNAN, P_ZERO, 64'h100, F_NONE);
	add_case(OP_CLASS, 3'd0, QNAN, P_ZERO, 64'h200, F_NONE);

	// compare with mod 0 fle, mod 1 flt and mod 2 feq
	add_case(OP_CMP, 3'd0, P_ONE, P_TWO, 64'h1, F_NONE);
	add_case(OP_CMP, 3'd1, P_TWO, P_ONE, 64'h0, F_NONE);
	add_case(OP_CMP, 3'd1, M_TWO, M_ONE, 64'h1, F_NONE);
	add_case(OP_CMP, 3'd1, M_ONE, P_ONE, 64'h1, F_NONE);
	add_case(OP_CMP, 3'd2, P_ONE, P_ONE, 64'h1, F_NONE);
	add_case(OP_CMP, 3'd0, M_ZERO, P_ZERO, 64'h1, F_NONE);
	add_case(OP_CMP, 3'd1, M_ZERO, P_ZERO, 64'h0, F_NONE);
	add_case(OP_CMP, 3'd2, P_ZERO, M_ZERO, 64'h1, F_NONE);
	add_case(OP_CMP, 3'd0, QNAN, P_ONE, 64'h0, F_NV);
	add_case(OP_CMP, 3'd1, P_ONE, QNAN, 64'h0, F_NV);
	add_case(OP_CMP, 3'd2, QNAN, P_ONE, 64'h0, F_NONE);     // quiet NaN stays quiet
	add_case(OP_CMP, 3'd2, SNAN, P_ONE, 64'h0, F_NV);

	// min/max with mod 0 min and mod 1 max
	add_case(OP_MINMAX, 3'd0, P_ONE, P_TWO, P_ONE, F_NONE);
	add_case(OP_MINMAX, 3'd1, P_ONE, P_TWO, P_TWO, F_NONE);
	add_case(OP_MINMAX, 3'd0, M_1P5, P_ONE, M_1P5, F_NONE);
	add_case(OP_MINMAX, 3'd0, P_ZERO, M_ZERO, M_ZERO, F_NONE);
	add_case(OP_MINMAX, 3'd1, M_ZERO, P_ZERO, P_ZERO, F_NONE);
	add_case(OP_MINMAX, 3'd0, QNAN, P_TWO, P_TWO, F_NONE);
	add_case(OP_MINMAX, 3'd1, P_THREE, QNAN, P_THREE, F_NONE);
	add_case(OP_MINMAX, 3'd0, QNAN_PN, QNAN_PP, QNAN, F_NONE);  // neither payload survives
	add_case(OP_MINMAX, 3'd1, SNAN, P_ONE, P_ONE, F_NV);

	// float to 64-bit integer
	add_case(OP_F2I, 3'd0, P_2P5, P_ZERO, 64'h2, F_NX);
	add_case(OP_F2I, 3'd0, M_2P5, P_ZERO, 64'hFFFF_FFFF_FFFF_FFFE, F_NX);
	add_case(OP_F2I, 3'd0, P_2E64, P_ZERO, 64'h7FFF_FFFF_FFFF_FFFF, F_NV);
	add_case(OP_F2I, 3'd0, M_INF, P_ZERO, 64'h8000_0000_0000_0000, F_NV);
	add_case(OP_F2I, 3'd0, QNAN, P_ZERO, 64'h7FFF_FFFF_FFFF_FFFF, F_NV);
	add_case(OP_F2IU, 3'd0, P_2E63, P_ZERO, 64'h8000_0000_0000_0000, F_NONE);
	add_case(OP_F2IU, 3'd0, M_ONE, P_ZERO, 64'h0, F_NV);
	add_case(OP_F2IU, 3'd0, M_HALF, P_ZERO, 64'h0, F_NX);   // truncates to zero first

	// float to 32-bit integer with sign extension
	use_formats(FMT_FP64, FMT_FP64, INT32);
	add_case(OP_F2I, 3'd0, P_THREE, P_ZERO, 64'h3, F_NONE);
	add_case(OP_F2I, 3'd0, M_1P5, P_ZERO, 64'hFFFF_FFFF_FFFF_FFFF, F_NX);
	add_case(OP_F2I, 3'd0, P_2E31, P_ZERO, 64'h0000_0000_7FFF_FFFF, F_NV);
	add_case(OP_F2I, 3'd0, M_2E31, P_ZERO, 64'hFFFF_FFFF_8000_0000, F_NONE);
	add_case(OP_F2I, 3'd0, M_2E32, P_ZERO, 64'hFFFF_FFFF_8000_0000, F_NV);
	add_case(OP_F2IU, 3'd0, P_THREE, P_ZERO, 64'h3, F_NONE);
	add_case(OP_F2IU, 3'd0, P_HALF, P_ZERO, 64'h0, F_NX);
	add_case(OP_F2IU, 3'd0, P_2E32, P_ZERO, 64'hFFFF_FFFF_FFFF_FFFF, F_NV);

	// double to single with NaN boxing
	use_formats(FMT_FP64, FMT_FP32, INT64);
	add_case(OP_F2F, 3'd0, P_ONE, P_ZERO, 64'hFFFF_FFFF_3F80_0000, F_NONE);
	add_case(OP_F2F, 3'd0, M_2P5, P_ZERO, 64'hFFFF_FFFF_C020_0000, F_NONE);
	add_case(OP_F2F, 3'd0, 64'h3FF0_0000_0000_0001, P_ZERO, 64'hFFFF_FFFF_3F80_0000, F_NX);
	add_case(OP_F2F, 3'd0, 64'h4C70_0000_0000_0000, P_ZERO, 64'hFFFF_FFFF_7F80_0000, F_OF);
	add_case(OP_F2F, 3'd0, 64'hCC70_0000_0000_0000, P_ZERO, 64'hFFFF_FFFF_FF80_0000, F_OF);
	add_case(OP_F2F, 3'd0, 64'h3370_0000_0000_0000, P_ZERO, 64'hFFFF_FFFF_0000_0000, F_UF);
	add_case(OP_F2F, 3'd0, QNAN_PN, P_ZERO, 64'hFFFF_FFFF_7FC0_0000, F_NONE);
	add_case(OP_F2F, 3'd0, P_INF, P_ZERO, 64'hFFFF_FFFF_7F80_0000, F_NONE);

	// single to double
	use_formats(FMT_FP32, FMT_FP64, INT64);
	add_case(OP_F2F, 3'd0, 64'hFFFF_FFFF_3FC0_0000, P_ZERO, P_1P5, F_NONE);
	add_case(OP_F2F, 3'd0, 64'hFFFF_FFFF_C000_0000, P_ZERO, M_TWO, F_NONE);
	add_case(OP_F2F, 3'd0, 64'hFFFF_FFFF_0000_0001, P_ZERO, P_ZERO, F_NONE);
	add_case(OP_F2F, 3'd0, 64'hFFFF_FFFF_8000_0001, P_ZERO, M_ZERO, F_NONE);

	use_formats(FMT_FP32, FMT_FP32, INT64);
	add_case(OP_F2F, 3'd0, P_ONE, P_ZERO, QNAN, F_NV);      // no such format pair
endtask

`endif

/* testbench/tb_fpu_misc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_misc import fpu_float_pkg::*, fpu_op_pkg::*;
();

	localparam int LATENCY = 3;
	localparam int TIMEOUT = 50;   // cycles to wait for ready

	typedef struct packed {
		fpu_op_e    op;
		op_mod_t    mod;
		fmt_e       src_fmt;
		fmt_e       dst_fmt;
		int_fmt_e   int_fmt;
		fp64_t      opa;
		fp64_t      opb;
		fp64_t      exp_out;
		fpu_flags_t exp_flags;
	} test_vec_t;

	logic       clk = 1'b0;
	logic       rst;
	logic       enable;
	fpu_op_e    fpu_op;
	op_mod_t    op_mod;
	fmt_e       src_fmt;
	fmt_e       dst_fmt;
	int_fmt_e   int_fmt;
	fp64_t      opa;
	fp64_t      opb;
	fp64_t      out;
	fpu_flags_t flags;
	logic       ready;

	test_vec_t vectors[$];
	fmt_e      cur_src;      // formats for the entries that follow
	fmt_e      cur_dst;
	int_fmt_e  cur_int;
	int        errors = 0;
	int        total = 0;
	int        passed = 0;
	logic      timed_out = 1'b0;

	fpu_misc_top #(
		.RESULT_LATENCY(LATENCY)
	) dut_i (
		.clk(clk), .rst(rst), .enable(enable),
		.fpu_op(fpu_op), .op_mod(op_mod),
		.src_fmt(src_fmt), .dst_fmt(dst_fmt), .int_fmt(int_fmt),
		.opa(opa), .opb(opb),
		.out(out), .flags(flags), .ready(ready)
	);

	always #10 clk = ~clk;

	task automatic use_formats(input fmt_e src, input fmt_e dst, input int_fmt_e ifmt);
		cur_src = src;
		cur_dst = dst;
		cur_int = ifmt;
	endtask

	task automatic add_case(input fpu_op_e op, input op_mod_t mod, input fp64_t a,
		input fp64_t b, input fp64_t exp_out, input fpu_flags_t exp_flags);
		test_vec_t v;
		v = '{op: op, mod: mod, src_fmt: cur_src, dst_fmt: cur_dst, int_fmt: cur_int,
			opa: a, opb: b, exp_out: exp_out, exp_flags: exp_flags};
		vectors.push_back(v);
	endtask

	`include "tb_vectors.svh"

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_value(input string name, input fp64_t got, input fp64_t expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, got);
			errors++;
		end
	endtask

	task automatic check_flags(input string name, input fpu_flags_t got, input fpu_flags_t expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, got);
			errors++;
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, got);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input int got, input int expected);
		if (got != expected)
		begin
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, got);
			errors++;
		end
	endtask

	// one start, wait for ready, compare; called on a falling edge
	task automatic run_case(input int idx, input test_vec_t v);
		int cycles;
		int errs_before;
		errs_before = errors;
		enable = 1'b0;
		@(negedge clk);
		fpu_op  = v.op;
		op_mod  = v.mod;
		src_fmt = v.src_fmt;
		dst_fmt = v.dst_fmt;
		int_fmt = v.int_fmt;
		opa     = v.opa;
		opb     = v.opb;
		enable  = 1'b1;
		@(negedge clk);   // start edge is behind us
		cycles = 0;
		while (!ready && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!ready)
		begin
			$display("test %0d: ready did not rise within %0d cycles", idx, TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
		else
		begin
			check_latency("ready latency", cycles, LATENCY);
			check_value("out", out, v.exp_out);
			check_flags("flags", flags, v.exp_flags);
		end
		total++;
		if (errors == errs_before)
			passed++;
		$display("test %0d %s mod %0d: %s", idx, v.op.name(), v.mod,
			(errors == errs_before) ? "pass" : "fail");
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial
	begin
		int errs_before;
		rst     = 1'b1;
		enable  = 1'b0;
		fpu_op  = OP_SGNJ;
		op_mod  = '0;
		src_fmt = FMT_FP64;
		dst_fmt = FMT_FP64;
		int_fmt = INT64;
		opa     = '0;
		opb     = '0;
		load_table();

		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		errs_before = errors;
		check_ready("ready", ready, 1'b0);
		check_value("out", out, '0);
		check_flags("flags", flags, '0);
		total++;
		if (errors == errs_before)
			passed++;
		$display("reset state: %s", (errors == errs_before) ? "pass" : "fail");

		foreach (vectors[i])
		begin
			run_case(i, vectors[i]);
			if (timed_out)
				break;
		end

		$display("%0d tests run, %0d passed, %0d failed", total, passed, total - passed);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
